// File: project.f
+incdir+src
src/icache_pkg.sv
src/icache_array.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_top.sv
verif/icache_mem_model.sv
verif/icache_asserts.sv
verif/icache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f project.f --top-module icache_tb -o sim_icache \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_icache > sim.log 2>&1 ; cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: verif/icache_tb.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb;
    import icache_pkg::*;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic                      hit;
    } fetch_entry_t;

    localparam int NUM_TESTS       = 24;
    localparam int MAX_WAIT        = 20;
    localparam int IDLE_CHECKS     = 4;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 10 + 100;

    logic                      clk;
    logic                      rst;
    logic                      fetch_en;
    logic [`ICACHE_ADDR_W-1:0] fetch_addr;
    icache_fetch_rsp_t         fetch_rsp;
    icache_mem_req_t           mem_req;
    icache_mem_rsp_t           mem_rsp;

    fetch_entry_t tests [NUM_TESTS];
    string        cur_name;
    int           test_errors;
    int           error_count;
    int           tests_failed;

    icache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .i_fetch_en   (fetch_en),
        .i_fetch_addr (fetch_addr),
        .o_fetch      (fetch_rsp),
        .o_mem        (mem_req),
        .i_mem        (mem_rsp)
    );

    icache_mem_model #(
        .SEED (32'h05d7367f)
    ) u_mem (
        .clk   (clk),
        .rst   (rst),
        .i_req (mem_req),
        .o_rsp (mem_rsp)
    );

    always #4 clk = ~clk;

    // set = bits 8..3, tag = bits 63..9, bit 2 picks the word
    function automatic void load_table();
        // set 0, cold miss then both words hit
        tests[0]  = '{addr: 64'h0000_0000_8000_0000, hit: 1'b0};
        tests[1]  = '{addr: 64'h0000_0000_8000_0004, hit: 1'b1};
        tests[2]  = '{addr: 64'h0000_0000_8000_0000, hit: 1'b1};
        // set 5, tags A and B fill way 0 and way 1
        tests[3]  = '{addr: 64'h0000_0000_8000_0028, hit: 1'b0};
        tests[4]  = '{addr: 64'h0000_0000_8000_102c, hit: 1'b0};
        tests[5]  = '{addr: 64'h0000_0000_8000_002c, hit: 1'b1};
        tests[6]  = '{addr: 64'h0000_0000_8000_1028, hit: 1'b1};
        // tag C evicts A, the older one
        tests[7]  = '{addr: 64'h0000_0000_8000_2028, hit: 1'b0};
        tests[8]  = '{addr: 64'h0000_0000_8000_1028, hit: 1'b1};
        tests[9]  = '{addr: 64'h0000_0000_8000_0028, hit: 1'b0};
        tests[10] = '{addr: 64'h0000_0000_8000_102c, hit: 1'b1};
        // set 9, tags differ only in bit 32
        tests[11] = '{addr: 64'h0000_0000_8000_0048, hit: 1'b0};
        tests[12] = '{addr: 64'h0000_0001_8000_0048, hit: 1'b0};
        tests[13] = '{addr: 64'h0000_0000_8000_0048, hit: 1'b1};
        tests[14] = '{addr: 64'h0000_0001_8000_004c, hit: 1'b1};
        // sets 63, 32 and 1
        tests[15] = '{addr: 64'h0000_0000_8000_01f8, hit: 1'b0};
        tests[16] = '{addr: 64'h0000_0000_8000_0100, hit: 1'b0};
        tests[17] = '{addr: 64'h0000_0000_8000_01fc, hit: 1'b1};
        tests[18] = '{addr: 64'h0000_0000_8000_0104, hit: 1'b1};
        tests[19] = '{addr: 64'h0000_0000_8000_0008, hit: 1'b0};
        // back to set 0, second tag goes to the empty way 1
        tests[20] = '{addr: 64'h0000_0000_8000_0000, hit: 1'b1};
        tests[21] = '{addr: 64'h0000_0000_8000_0200, hit: 1'b0};
        tests[22] = '{addr: 64'h0000_0000_8000_0004, hit: 1'b1};
        tests[23] = '{addr: 64'h0000_0000_8000_0204, hit: 1'b1};
    endfunction

    // word the memory stand-in returns for this fetch address
    function automatic logic [31:0] expected_inst(input logic [63:0] addr);
        logic [31:0] line_addr;
        line_addr = {addr[31:3], 3'b000};
        if (addr[2]) begin
            return line_addr ^ 32'h2468_ace0;
        end
        return line_addr ^ 32'h1357_9bdf;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s %s got 0x%h expected 0x%h", cur_name, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_value("o_fetch.valid", {63'b0, fetch_rsp.valid}, 64'h0);
            compare_value("o_mem.rd", {63'b0, mem_req.rd}, 64'h0);
        end
    endtask

    task automatic run_fetch(input int idx);
        fetch_entry_t e;
        int           lat;
        logic         got_valid;
        logic         saw_rd;
        logic [31:0]  rd_addr;
        logic [31:0]  inst;
        e           = tests[idx];
        lat         = 0;
        got_valid   = 1'b0;
        saw_rd      = 1'b0;
        rd_addr     = '0;
        inst        = '0;
        test_errors = 0;
        cur_name    = $sformatf("test %0d", idx);

        @(posedge clk);
        fetch_en   <= 1'b1;
        fetch_addr <= e.addr;
        // strobe lasts one cycle, outputs sampled mid-cycle
        while (!got_valid && lat < MAX_WAIT) begin
            @(posedge clk);
            lat++;
            fetch_en <= 1'b0;
            @(negedge clk);
            if (mem_req.rd) begin
                saw_rd  = 1'b1;
                rd_addr = mem_req.addr;
            end
            if (fetch_rsp.valid) begin
                got_valid = 1'b1;
                inst      = fetch_rsp.inst;
            end
        end

        assert (got_valid) else begin
            $display("%s: no valid pulse within %0d cycles of the fetch", cur_name, MAX_WAIT);
            test_errors++;
        end
        if (got_valid) begin
            compare_value("o_mem.rd", {63'b0, saw_rd}, {63'b0, ~e.hit});
            if (e.hit) begin
                assert (lat == 2) else begin
                    $display("%s: hit answered after %0d cycles instead of 2", cur_name, lat);
                    test_errors++;
                end
            end else begin
                compare_value("o_mem.addr", {32'b0, rd_addr}, {32'b0, e.addr[31:3], 3'b000});
            end
            compare_value("o_fetch.inst", {32'b0, inst}, {32'b0, expected_inst(e.addr)});
        end

        $display("%s addr 0x%h %s after %0d cycles, %s", cur_name, e.addr,
                 e.hit ? "hit " : "miss", lat, test_errors == 0 ? "passed" : "failed");
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        fetch_en     = 1'b0;
        fetch_addr   = '0;
        error_count  = 0;
        tests_failed = 0;
        load_table();

        repeat (3) @(posedge clk);
        rst <= 1'b1;

        // nothing moves before the first fetch
        cur_name    = "reset";
        test_errors = 0;
        check_idle(IDLE_CHECKS);
        $display("reset: valid and read level low for %0d idle cycles, %s",
                 IDLE_CHECKS, test_errors == 0 ? "passed" : "failed");
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_fetch(i);
        end

        $display("tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 NUM_TESTS + 1, NUM_TESTS + 1 - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verif/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts (
    input logic                          clk,
    input logic                          rst,
    input icache_pkg::icache_fetch_rsp_t i_fetch,
    input icache_pkg::icache_mem_req_t   i_mem_req,
    input icache_pkg::icache_mem_rsp_t   i_mem_rsp
);

    logic valid;
    logic rd;
    logic ok;

    assign valid = i_fetch.valid;
    assign rd    = i_mem_req.rd;
    assign ok    = i_mem_rsp.ok;

    // valid is a single-cycle pulse
    valid_one_cycle: assert property (
        @(posedge clk) disable iff (!rst) valid |=> !valid
    ) else $error("fetch valid stayed high for more than one cycle");

    // read level is held until memory answers
    rd_held_until_ok: assert property (
        @(posedge clk) disable iff (!rst) (rd && !ok) |=> rd
    ) else $error("memory read level dropped before ok");

    rd_not_with_valid: assert property (
        @(posedge clk) disable iff (!rst) !(rd && valid)
    ) else $error("memory read level and fetch valid high together");

    // ok only answers an open read
    ok_only_during_rd: assert property (
        @(posedge clk) disable iff (!rst) ok |-> rd
    ) else $error("memory ok seen without a read level");

endmodule

bind icache_top icache_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .i_fetch   (o_fetch),
    .i_mem_req (o_mem),
    .i_mem_rsp (i_mem)
);

// File: verif/icache_mem_model.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_mem_model #(
    parameter logic [31:0] SEED = 32'h05d7367f
) (
    input  logic                        clk,
    input  logic                        rst,
    input  icache_pkg::icache_mem_req_t i_req,
    output icache_pkg::icache_mem_rsp_t o_rsp
);
    import icache_pkg::*;

    logic                          busy;
    logic                          answered;
    logic [`ICACHE_MEM_ADDR_W-1:0] addr_q;
    int unsigned                   wait_left;

    // lower word and upper word are the line address under two masks
    function automatic icache_line_t line_for(input logic [`ICACHE_MEM_ADDR_W-1:0] line_addr);
        return {line_addr ^ 32'h2468_ace0, line_addr ^ 32'h1357_9bdf};
    endfunction

    initial begin
        void'($urandom(SEED));
        busy      = 1'b0;
        answered  = 1'b0;
        addr_q    = '0;
        wait_left = 0;
        o_rsp     = '0;
        forever begin
            @(posedge clk or negedge rst);
            if (!rst) begin
                busy     = 1'b0;
                answered = 1'b0;
                o_rsp    <= '0;
            end else if (answered) begin
                // controller takes ok at this edge and drops the read level
                answered = 1'b0;
                o_rsp    <= '0;
            end else begin
                if (!busy && i_req.rd) begin
                    busy      = 1'b1;
                    addr_q    = i_req.addr;
                    // 0 to 3 extra cycles, so 1 to 4 cycles in all
                    wait_left = $urandom % 4;
                end
                if (busy) begin
                    if (wait_left == 0) begin
                        busy     = 1'b0;
                        answered = 1'b1;
                        o_rsp    <= '{ok: 1'b1, line: line_for(addr_q)};
                    end else begin
                        wait_left = wait_left - 1;
                    end
                end
            end
        end
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_fetch_en,
    input  logic [`ICACHE_ADDR_W-1:0]     i_fetch_addr,
    output icache_pkg::icache_fetch_rsp_t o_fetch,
    output icache_pkg::icache_mem_req_t   o_mem,
    input  icache_pkg::icache_mem_rsp_t   i_mem
);
    import icache_pkg::*;

    icache_lookup_t  lookup;
    icache_way_rsp_t rsp0;
    icache_way_rsp_t rsp1;
    icache_way_upd_t upd0;
    icache_way_upd_t upd1;

    // fsm, victim choice and response
    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_fetch_en   (i_fetch_en),
        .i_fetch_addr (i_fetch_addr),
        .i_way0       (rsp0),
        .i_way1       (rsp1),
        .o_lookup     (lookup),
        .o_upd0       (upd0),
        .o_upd1       (upd1),
        .o_mem        (o_mem),
        .i_mem        (i_mem),
        .o_fetch      (o_fetch)
    );

    // both ways see the same lookup
    icache_way u_way0 (
        .clk      (clk),
        .rst      (rst),
        .i_lookup (lookup),
        .i_upd    (upd0),
        .o_rsp    (rsp0)
    );

    icache_way u_way1 (
        .clk      (clk),
        .rst      (rst),
        .i_lookup (lookup),
        .i_upd    (upd1),
        .o_rsp    (rsp1)
    );

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_fetch_en,
    input  logic [`ICACHE_ADDR_W-1:0]     i_fetch_addr,
    input  icache_pkg::icache_way_rsp_t   i_way0,
    input  icache_pkg::icache_way_rsp_t   i_way1,
    output icache_pkg::icache_lookup_t    o_lookup,
    output icache_pkg::icache_way_upd_t   o_upd0,
    output icache_pkg::icache_way_upd_t   o_upd1,
    output icache_pkg::icache_mem_req_t   o_mem,
    input  icache_pkg::icache_mem_rsp_t   i_mem,
    output icache_pkg::icache_fetch_rsp_t o_fetch
);
    import icache_pkg::*;

    icache_state_e             state;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic                      victim_q;
    logic [`ICACHE_INST_W-1:0] inst_q;

    logic                      lookup_hit;
    logic                      hit_done;
    logic                      fill_done;
    logic                      victim;
    icache_line_t              hit_line;

    // bit 2 of the address picks the upper instruction
    function automatic logic [`ICACHE_INST_W-1:0] pick_word(
        input icache_line_t line,
        input logic         upper
    );
        return upper ? line[`ICACHE_LINE_W-1 -: `ICACHE_INST_W] : line[`ICACHE_INST_W-1:0];
    endfunction

    // in IDLE the ways see the fetch address, later the latched one
    always_comb begin
        o_lookup.rd = (state == IDLE) && i_fetch_en;
        if (state == IDLE) begin
            o_lookup.idx = i_fetch_addr[`ICACHE_OFFSET_W +: `ICACHE_IDX_W];
            o_lookup.tag = i_fetch_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        end else begin
            o_lookup.idx = addr_q[`ICACHE_OFFSET_W +: `ICACHE_IDX_W];
            o_lookup.tag = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        end
    end

    assign lookup_hit = i_way0.hit || i_way1.hit;
    assign hit_line   = i_way0.hit ? i_way0.line : i_way1.line;
    assign hit_done   = (state == LOOKUP) && lookup_hit;
    assign fill_done  = (state == REFILL) && i_mem.ok;

    // invalid way first, then the older one, ties to way 0
    assign victim = i_way0.valid && (!i_way1.valid || (i_way1.age > i_way0.age));

    always_comb begin
        o_upd0.fill      = fill_done && !victim_q;
        o_upd0.fill_line = i_mem.line;
        o_upd0.access    = hit_done || fill_done;
        o_upd0.sel       = (state == LOOKUP) ? i_way0.hit : !victim_q;

        o_upd1.fill      = fill_done && victim_q;
        o_upd1.fill_line = i_mem.line;
        o_upd1.access    = hit_done || fill_done;
        o_upd1.sel       = (state == LOOKUP) ? !i_way0.hit : victim_q;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_fetch_en) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= lookup_hit ? RESPOND : REFILL;
                end
                REFILL: begin
                    if (i_mem.ok) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // fetch address, victim and returned word
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_fetch_en) begin
            addr_q <= i_fetch_addr;
        end
        if ((state == LOOKUP) && !lookup_hit) begin
            victim_q <= victim;
        end
        if (hit_done) begin
            inst_q <= pick_word(hit_line, addr_q[`ICACHE_OFFSET_W-1]);
        end else if (fill_done) begin
            inst_q <= pick_word(i_mem.line, addr_q[`ICACHE_OFFSET_W-1]);
        end
    end

    // read level held for the whole refill
    assign o_mem.rd   = (state == REFILL);
    assign o_mem.addr = {addr_q[`ICACHE_MEM_ADDR_W-1:`ICACHE_OFFSET_W],
                         {`ICACHE_OFFSET_W{1'b0}}};

    assign o_fetch.valid = (state == RESPOND);
    assign o_fetch.inst  = inst_q;

endmodule

// File: src/icache_way.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_way (
    input  logic                        clk,
    input  logic                        rst,
    input  icache_pkg::icache_lookup_t  i_lookup,
    input  icache_pkg::icache_way_upd_t i_upd,
    output icache_pkg::icache_way_rsp_t o_rsp
);
    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0]  valid_bits;
    logic [`ICACHE_AGE_W-1:0] age_q [`ICACHE_SETS];

    logic [`ICACHE_IDX_W-1:0] idx_q;
    icache_tag_t              tag_q;
    icache_tag_t              tag_rd;
    icache_line_t             line_rd;

    // tag and line storage share the set index from the lookup
    icache_array #(
        .T     (icache_tag_t),
        .DEPTH (`ICACHE_SETS)
    ) u_tag_array (
        .clk       (clk),
        .i_wr_en   (i_upd.fill),
        .i_addr    (i_lookup.idx),
        .i_wr_data (i_lookup.tag),
        .o_rd_data (tag_rd)
    );

    icache_array #(
        .T     (icache_line_t),
        .DEPTH (`ICACHE_SETS)
    ) u_line_array (
        .clk       (clk),
        .i_wr_en   (i_upd.fill),
        .i_addr    (i_lookup.idx),
        .i_wr_data (i_upd.fill_line),
        .o_rd_data (line_rd)
    );

    // remember which set and tag were asked for
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_q <= '0;
        end else if (i_lookup.rd) begin
            idx_q <= i_lookup.idx;
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup.rd) begin
            tag_q <= i_lookup.tag;
        end
    end

    // valid bits and ages of the looked-up set
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age_q[s] <= '0;
            end
        end else begin
            if (i_upd.fill) begin
                valid_bits[idx_q] <= 1'b1;
            end
            if (i_upd.access) begin
                if (i_upd.sel) begin
                    age_q[idx_q] <= '0;
                end else if (age_q[idx_q] != '1) begin
                    age_q[idx_q] <= age_q[idx_q] + 1'b1;
                end
            end
        end
    end

    assign o_rsp.valid = valid_bits[idx_q];
    assign o_rsp.age   = age_q[idx_q];
    assign o_rsp.hit   = valid_bits[idx_q] && (tag_rd == tag_q);
    assign o_rsp.line  = line_rd;

endmodule

// File: src/icache_array.sv
`timescale 1ns/1ps

module icache_array #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  T                         i_wr_data,
    output T                         o_rd_data
);

    // storage, contents are only meaningful once the way marks a set valid
    T mem [DEPTH];

    // one port, read every cycle
    // a write to the addressed entry shows up on the read side at once
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            o_rd_data <= i_wr_data;
        end else begin
            o_rd_data <= mem[i_addr];
        end
    end

endmodule

// File: src/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]  icache_tag_t;
    typedef logic [`ICACHE_LINE_W-1:0] icache_line_t;

    // request broadcast to both ways
    typedef struct packed {
        logic                     rd;
        logic [`ICACHE_IDX_W-1:0] idx;
        icache_tag_t              tag;
    } icache_lookup_t;

    typedef struct packed {
        logic                     hit;
        logic                     valid;
        logic [`ICACHE_AGE_W-1:0] age;
        icache_line_t             line;
    } icache_way_rsp_t;

    // fill writes tag and line, access ages the set
    typedef struct packed {
        logic         fill;
        icache_line_t fill_line;
        logic         access;
        logic         sel;
    } icache_way_upd_t;

    typedef struct packed {
        logic                          rd;
        logic [`ICACHE_MEM_ADDR_W-1:0] addr;
    } icache_mem_req_t;

    typedef struct packed {
        logic         ok;
        icache_line_t line;
    } icache_mem_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_INST_W-1:0] inst;
    } icache_fetch_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } icache_state_e;

endpackage

// File: src/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry
`define ICACHE_SETS        64
`define ICACHE_IDX_W       6
`define ICACHE_LINE_BYTES  8
`define ICACHE_OFFSET_W    $clog2(`ICACHE_LINE_BYTES)

// address split, tag is bits 63..9
`define ICACHE_ADDR_W      64
`define ICACHE_TAG_W       55
`define ICACHE_MEM_ADDR_W  32

// payload widths
`define ICACHE_LINE_W      64
`define ICACHE_INST_W      32

// per-set age counter, saturates at all ones
`define ICACHE_AGE_W       3

`endif
